// File: Makefile
TOP = buzzerSocTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

# Pass only if the simulation prints the pass message
run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: buzzer/pwmGen.sv
`timescale 1ns/1ns
`default_nettype none

module pwmGen #(
    parameter int DUTY_BITS = 6
) (
    input  logic                                clk,
    input  logic                                RSTn,
    input  logic [buzzerPkg::SAMPLE_WIDTH-1:0]  sample,
    input  logic                                sampleValid,
    output logic                                sampleReady,
    output logic                                pwm,
    output logic                                playing
);

    localparam logic [DUTY_BITS-1:0] LAST_CNT = '1;

    logic [DUTY_BITS-1:0] cnt;
    logic [DUTY_BITS-1:0] duty;
    logic                 xfer;

    // ------------------------------
    // Handshake with the fetch stage
    // ------------------------------
    // Ready while idle or in the last cycle of a period
    assign sampleReady = ~playing | (cnt == LAST_CNT);
    assign xfer        = sampleValid & sampleReady;

    // ------------------------------
    // Period counter
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            playing <= 1'b0;
            cnt     <= '0;
        end else if (xfer) begin
            playing <= 1'b1;
            cnt     <= '0;
        end else if (playing) begin
            // No new sample at the boundary, go idle
            if (cnt == LAST_CNT)
                playing <= 1'b0;
            cnt <= cnt + 1'b1;
        end
    end

    // Duty from the top bits of the sample
    always_ff @(posedge clk) begin
        if (xfer)
            duty <= sample[buzzerPkg::SAMPLE_WIDTH-1 -: DUTY_BITS];
    end

    // High for the first duty cycles of the period
    assign pwm = playing & (cnt < duty);

endmodule

`default_nettype wire

// File: buzzer/sampleFetch.sv
`timescale 1ns/1ns
`default_nettype none

module sampleFetch #(
    parameter int RAM_WORDS = 512,
    localparam int RAM_AW = $clog2(RAM_WORDS),
    localparam int CNT_W = RAM_AW + 1
) (
    input  logic                                clk,
    input  logic                                RSTn,
    input  logic                                start,
    input  logic                                stop,
    input  logic [RAM_AW-1:0]                   baseWord,
    input  logic [CNT_W-1:0]                    sampleCount,
    output logic                                fetchRe,
    output logic [RAM_AW-1:0]                   fetchAddr,
    input  logic [buzzerPkg::DATA_WIDTH-1:0]    fetchData,
    output logic                                sampleValid,
    output logic [buzzerPkg::SAMPLE_WIDTH-1:0]  sample,
    input  logic                                sampleReady,
    output logic                                fetchBusy
);

    logic [CNT_W-1:0]       wordsLeft;
    logic [CNT_W-1:0]       samplesLeft;
    logic                   pending;
    logic                   haveNext;
    logic                   hiSel;
    buzzerPkg::sampleWord_u bufWord;
    logic                   xfer;
    logic                   avail;
    logic                   load;

    assign xfer  = sampleValid & sampleReady;

    // Word ready at the RAM output, just arrived or parked there
    assign avail = pending | haveNext;

    // Move it into the buffer once the buffer is empty or drains now
    assign load  = avail & (~sampleValid | (xfer & hiSel));

    // One read in flight at most, only into a free output slot
    assign fetchRe = fetchBusy & (wordsLeft != '0) & (~avail | load);

    // Low half first, then high half
    assign sample = hiSel ? bufWord.half.high : bufWord.half.low;

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            fetchBusy   <= 1'b0;
            fetchAddr   <= '0;
            wordsLeft   <= '0;
            samplesLeft <= '0;
            pending     <= 1'b0;
            haveNext    <= 1'b0;
            sampleValid <= 1'b0;
            hiSel       <= 1'b0;
        end else if (stop || (fetchBusy && xfer && samplesLeft == CNT_W'(1))) begin
            // Abort, or the last sample has gone
            fetchBusy   <= 1'b0;
            pending     <= 1'b0;
            haveNext    <= 1'b0;
            sampleValid <= 1'b0;
            hiSel       <= 1'b0;
        end else if (!fetchBusy) begin
            if (start && sampleCount != '0) begin
                fetchBusy   <= 1'b1;
                fetchAddr   <= baseWord;
                samplesLeft <= sampleCount;
                wordsLeft   <= (sampleCount >> 1) + CNT_W'(sampleCount[0]);
            end
        end else begin
            pending  <= fetchRe;
            haveNext <= avail & ~load;
            if (fetchRe) begin
                fetchAddr <= fetchAddr + 1'b1;
                wordsLeft <= wordsLeft - 1'b1;
            end
            if (xfer)
                samplesLeft <= samplesLeft - 1'b1;
            if (load) begin
                sampleValid <= 1'b1;
                hiSel       <= 1'b0;
            end else if (xfer) begin
                if (hiSel)
                    sampleValid <= 1'b0;
                else
                    hiSel <= 1'b1;
            end
        end
    end

    // Buffered word
    always_ff @(posedge clk) begin
        if (load)
            bufWord.raw <= fetchData;
    end

endmodule

`default_nettype wire

// File: common/buzzerPkg.sv
`default_nettype none

package buzzerPkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int DATA_WIDTH   = 32;
    localparam int SAMPLE_WIDTH = 16;

    // ------------------------------
    // Register map, word offsets in the register window
    // ------------------------------
    localparam int REG_CTRL   = 0;
    localparam int REG_BASE   = 1;
    localparam int REG_COUNT  = 2;
    localparam int REG_STATUS = 3;

    // CTRL bits, write-only pulses
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_STOP_BIT  = 1;

    // STATUS bit 0 is busy

    // ------------------------------
    // Sample word, two samples per RAM word, low half played first
    // ------------------------------
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        struct packed {
            logic [SAMPLE_WIDTH-1:0] high;
            logic [SAMPLE_WIDTH-1:0] low;
        } half;
    } sampleWord_u;

endpackage

`default_nettype wire

// File: hw/busDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module busDecoder #(
    parameter int ADDR_WIDTH = 10,
    parameter int RAM_WORDS = 512,
    localparam int RAM_AW = $clog2(RAM_WORDS),
    localparam int CNT_W = RAM_AW + 1
) (
    input  logic                              clk,
    input  logic                              RSTn,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [ADDR_WIDTH-1:0]             adr,
    input  logic [buzzerPkg::DATA_WIDTH-1:0]  datW,
    output logic [buzzerPkg::DATA_WIDTH-1:0]  datR,
    output logic                              ack,
    output logic                              ramWe,
    output logic [RAM_AW-1:0]                 ramAddr,
    output logic [buzzerPkg::DATA_WIDTH-1:0]  ramWData,
    input  logic [buzzerPkg::DATA_WIDTH-1:0]  ramRData,
    output logic                              start,
    output logic                              stop,
    output logic [RAM_AW-1:0]                 baseWord,
    output logic [CNT_W-1:0]                  sampleCount,
    input  logic                              fetchBusy,
    input  logic                              playing
);

    localparam int OFF_W = ADDR_WIDTH - 1;

    logic                             access;
    logic                             regWin;
    logic                             regWrite;
    logic [OFF_W-1:0]                 regOff;
    logic                             isCtrl;
    logic                             isBase;
    logic                             isCount;
    logic                             isStatus;
    logic                             regSel;
    logic [buzzerPkg::DATA_WIDTH-1:0] regRData;
    logic [buzzerPkg::DATA_WIDTH-1:0] regRDataQ;

    // New transfer seen; the guard on ack keeps it to one ack per transfer
    assign access   = cyc & stb & ~ack;
    assign regWin   = adr[ADDR_WIDTH-1];
    assign regOff   = adr[OFF_W-1:0];
    assign regWrite = access & we & regWin;

    assign isCtrl   = (regOff == OFF_W'(buzzerPkg::REG_CTRL));
    assign isBase   = (regOff == OFF_W'(buzzerPkg::REG_BASE));
    assign isCount  = (regOff == OFF_W'(buzzerPkg::REG_COUNT));
    assign isStatus = (regOff == OFF_W'(buzzerPkg::REG_STATUS));

    // ------------------------------
    // RAM host port
    // ------------------------------
    assign ramWe    = access & we & ~regWin;
    assign ramAddr  = adr[RAM_AW-1:0];
    assign ramWData = datW;

    // Register read data, CTRL and unmapped offsets read zero
    always_comb begin
        regRData = '0;
        if (isBase)
            regRData[RAM_AW-1:0] = baseWord;
        if (isCount)
            regRData[CNT_W-1:0] = sampleCount;
        if (isStatus)
            regRData[0] = fetchBusy | playing;
    end

    // ------------------------------
    // Ack, pulses and registers
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            ack         <= 1'b0;
            regSel      <= 1'b0;
            start       <= 1'b0;
            stop        <= 1'b0;
            baseWord    <= '0;
            sampleCount <= '0;
        end else begin
            ack   <= access;
            start <= regWrite & isCtrl & datW[buzzerPkg::CTRL_START_BIT];
            stop  <= regWrite & isCtrl & datW[buzzerPkg::CTRL_STOP_BIT];
            if (access)
                regSel <= regWin;
            if (regWrite && isBase)
                baseWord <= datW[RAM_AW-1:0];
            if (regWrite && isCount)
                sampleCount <= datW[CNT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            regRDataQ <= regRData;
    end

    // Valid in the ack cycle, RAM data arrives one cycle after the address
    assign datR = regSel ? regRDataQ : ramRData;

endmodule

`default_nettype wire

// File: hw/buzzerSoc.sv
`timescale 1ns/1ns
`default_nettype none

module buzzerSoc #(
    parameter int ADDR_WIDTH = 10,
    parameter int RAM_WORDS = 512,
    parameter int DUTY_BITS = 6,
    localparam int RAM_AW = $clog2(RAM_WORDS),
    localparam int CNT_W = RAM_AW + 1
) (
    input  logic                              clk,
    input  logic                              RSTn,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [ADDR_WIDTH-1:0]             adr,
    input  logic [buzzerPkg::DATA_WIDTH-1:0]  datW,
    output logic [buzzerPkg::DATA_WIDTH-1:0]  datR,
    output logic                              ack,
    output logic                              pwm
);

    // ------------------------------
    // Stage connections
    // ------------------------------
    logic                                ramWe;
    logic [RAM_AW-1:0]                   ramAddr;
    logic [buzzerPkg::DATA_WIDTH-1:0]    ramWData;
    logic [buzzerPkg::DATA_WIDTH-1:0]    ramRData;
    logic                                start;
    logic                                stop;
    logic [RAM_AW-1:0]                   baseWord;
    logic [CNT_W-1:0]                    sampleCount;
    logic                                fetchRe;
    logic [RAM_AW-1:0]                   fetchAddr;
    logic [buzzerPkg::DATA_WIDTH-1:0]    fetchData;
    logic                                sampleValid;
    logic                                sampleReady;
    logic [buzzerPkg::SAMPLE_WIDTH-1:0]  sample;
    logic                                fetchBusy;
    logic                                playing;

    busDecoder #(.ADDR_WIDTH(ADDR_WIDTH), .RAM_WORDS(RAM_WORDS)) uBusDecoder (
        .clk(clk), .RSTn(RSTn), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWData(ramWData), .ramRData(ramRData),
        .start(start), .stop(stop), .baseWord(baseWord), .sampleCount(sampleCount),
        .fetchBusy(fetchBusy), .playing(playing)
    );

    sampleRam #(.RAM_WORDS(RAM_WORDS)) uSampleRam (
        .clk(clk), .ramWe(ramWe), .ramAddr(ramAddr), .ramWData(ramWData),
        .ramRData(ramRData), .fetchRe(fetchRe), .fetchAddr(fetchAddr),
        .fetchData(fetchData)
    );

    sampleFetch #(.RAM_WORDS(RAM_WORDS)) uSampleFetch (
        .clk(clk), .RSTn(RSTn), .start(start), .stop(stop), .baseWord(baseWord),
        .sampleCount(sampleCount), .fetchRe(fetchRe), .fetchAddr(fetchAddr),
        .fetchData(fetchData), .sampleValid(sampleValid), .sample(sample),
        .sampleReady(sampleReady), .fetchBusy(fetchBusy)
    );

    pwmGen #(.DUTY_BITS(DUTY_BITS)) uPwmGen (
        .clk(clk), .RSTn(RSTn), .sample(sample), .sampleValid(sampleValid),
        .sampleReady(sampleReady), .pwm(pwm), .playing(playing)
    );

endmodule

`default_nettype wire

// File: hw/sampleRam.sv
`timescale 1ns/1ns
`default_nettype none

module sampleRam #(
    parameter int RAM_WORDS = 512,
    localparam int RAM_AW = $clog2(RAM_WORDS)
) (
    input  logic                              clk,
    // Host port
    input  logic                              ramWe,
    input  logic [RAM_AW-1:0]                 ramAddr,
    input  logic [buzzerPkg::DATA_WIDTH-1:0]  ramWData,
    output logic [buzzerPkg::DATA_WIDTH-1:0]  ramRData,
    // Fetch port
    input  logic                              fetchRe,
    input  logic [RAM_AW-1:0]                 fetchAddr,
    output logic [buzzerPkg::DATA_WIDTH-1:0]  fetchData
);

    logic [buzzerPkg::DATA_WIDTH-1:0] mem [RAM_WORDS];

    // ------------------------------
    // Host port, write and registered read
    // ------------------------------
    always_ff @(posedge clk) begin
        if (ramWe)
            mem[ramAddr] <= ramWData;
        ramRData <= mem[ramAddr];
    end

    // ------------------------------
    // Fetch port
    // ------------------------------
    // Output holds its word until the next read is issued
    always_ff @(posedge clk) begin
        if (fetchRe)
            fetchData <= mem[fetchAddr];
    end

endmodule

`default_nettype wire

// File: sources.f
common/buzzerPkg.sv
hw/sampleRam.sv
hw/busDecoder.sv
buzzer/sampleFetch.sv
buzzer/pwmGen.sv
hw/buzzerSoc.sv
verif/buzzerSocChecker.sv
verif/buzzerSocTb.sv

// File: verif/buzzerSocChecker.sv
`timescale 1ns/1ns
`default_nettype none

module buzzerSocChecker (
    input  logic                                clk,
    input  logic                                RSTn,
    input  logic                                stop,
    input  logic                                sampleValid,
    input  logic                                sampleReady,
    input  logic [buzzerPkg::SAMPLE_WIDTH-1:0]  sample,
    input  logic                                fetchBusy,
    input  logic                                playing,
    input  logic                                pwm
);

    // ------------------------------
    // Fetch to PWM handshake
    // ------------------------------
    // A stop may drop the offer
    offerHeld: assert property (@(posedge clk) disable iff (!RSTn)
        sampleValid && !sampleReady && !stop |=> sampleValid && $stable(sample))
        else $error("sample offer changed before transfer");

    // Fetch keeps up so a period boundary during playback always finds a sample
    noGapWhileBusy: assert property (@(posedge clk) disable iff (!RSTn)
        playing && sampleReady && fetchBusy |-> sampleValid)
        else $error("no sample offered at a period boundary");

    // ------------------------------
    // PWM output
    // ------------------------------
    // Pulses begin only with a new period
    pwmRiseAfterXfer: assert property (@(posedge clk) disable iff (!RSTn)
        $rose(pwm) |-> $past(sampleValid && sampleReady))
        else $error("pwm rose without a sample transfer");

endmodule

bind buzzerSoc buzzerSocChecker uChecker (
    .clk(clk), .RSTn(RSTn), .stop(stop),
    .sampleValid(sampleValid), .sampleReady(sampleReady), .sample(sample),
    .fetchBusy(fetchBusy), .playing(playing), .pwm(pwm)
);

`default_nettype wire

// File: verif/buzzerSocTb.sv
`timescale 1ns/1ns
`default_nettype none

module buzzerSocTb;

    localparam int ADDR_WIDTH  = 10;
    localparam int RAM_WORDS   = 512;
    localparam int RAM_AW      = $clog2(RAM_WORDS);
    localparam int DUTY_BITS   = 6;
    localparam int PERIOD      = 1 << DUTY_BITS;
    localparam int ACK_TIMEOUT = 20;

    logic                             clk;
    logic                             RSTn;
    logic                             cyc;
    logic                             stb;
    logic                             we;
    logic [ADDR_WIDTH-1:0]            adr;
    logic [buzzerPkg::DATA_WIDTH-1:0] datW;
    logic [buzzerPkg::DATA_WIDTH-1:0] datR;
    logic                             ack;
    logic                             pwm;

    int          valueErrors;
    int          timeoutErrors;
    integer      seed;
    logic [31:0] model [int];
    int          expWidths [$];
    int          pulses [$];
    int          width;

    buzzerSoc UUT (
        .clk(clk), .RSTn(RSTn), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack), .pwm(pwm)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Pulse widths in clocks are pushed when pwm falls
    always @(negedge clk) begin
        if (pwm) begin
            width++;
        end else if (width != 0) begin
            pulses.push_back(width);
            width = 0;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [ADDR_WIDTH-1:0] regAddr(input int off);
        return {1'b1, (ADDR_WIDTH-1)'(off)};
    endfunction

    // Nonzero duty below the period in the top bits
    function automatic logic [15:0] sampleFromRandom(input logic [31:0] rnd);
        return {DUTY_BITS'(1 + int'(rnd[7:0]) % (PERIOD - 2)), rnd[17:8]};
    endfunction

    task automatic expectEqual(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            valueErrors++;
            $display("Fail at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // One Wishbone classic transfer followed by a check that ack drops
    task automatic runTransfer(input logic isWrite, input logic [ADDR_WIDTH-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int   waitCycles;
        logic gotAck;
        @(negedge clk);
        cyc        = 1'b1;
        stb        = 1'b1;
        we         = isWrite;
        adr        = addr;
        datW       = wdata;
        waitCycles = 0;
        gotAck     = 1'b0;
        while (!gotAck && waitCycles < ACK_TIMEOUT) begin
            @(negedge clk);
            gotAck = ack;
            waitCycles++;
        end
        assert (gotAck) else begin
            timeoutErrors++;
            $display("No ack for the bus access at address %0h", addr);
        end
        rdata = datR;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        @(negedge clk);
        assert (!ack) else begin
            valueErrors++;
            $display("Fail at %0t: second ack for address %0h", $time, addr);
        end
    endtask

    task automatic busWrite(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        runTransfer(1'b1, addr, data, unused);
    endtask

    task automatic busRead(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        runTransfer(1'b0, addr, '0, data);
    endtask

    // Poll STATUS until busy clears
    task automatic waitIdle(input int maxPolls);
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = 32'h1;
        while (status[0] && polls < maxPolls) begin
            busRead(regAddr(buzzerPkg::REG_STATUS), status);
            polls++;
        end
        assert (!status[0]) else begin
            timeoutErrors++;
            $display("Playback did not finish, busy is still set");
        end
    endtask

    // Two samples per word with the low half played first
    task automatic loadSamples(input int base, input int count);
        logic [15:0] lo;
        logic [15:0] hi;
        int          w;
        expWidths.delete();
        for (w = 0; w < (count + 1) / 2; w++) begin
            lo = sampleFromRandom($random(seed));
            hi = sampleFromRandom($random(seed));
            expWidths.push_back(int'(lo[15 -: DUTY_BITS]));
            if (2 * w + 1 < count)
                expWidths.push_back(int'(hi[15 -: DUTY_BITS]));
            busWrite(ADDR_WIDTH'(base + w), {hi, lo});
            model[base + w] = {hi, lo};
        end
    endtask

    task automatic startPlay(input int base, input int count);
        pulses.delete();
        busWrite(regAddr(buzzerPkg::REG_BASE), 32'(base));
        busWrite(regAddr(buzzerPkg::REG_COUNT), 32'(count));
        busWrite(regAddr(buzzerPkg::REG_CTRL), 32'(1 << buzzerPkg::CTRL_START_BIT));
    endtask

    task automatic checkPulses();
        int i;
        assert (pulses.size() == expWidths.size()) else begin
            valueErrors++;
            $display("Fail at %0t: %0d pulses, expected %0d", $time, pulses.size(),
                     expWidths.size());
        end
        for (i = 0; i < pulses.size() && i < expWidths.size(); i++)
            expectEqual(pulses[i], expWidths[i], "pulse width");
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic testIdle();
        logic [31:0] rdata;
        int          i;
        busRead(regAddr(buzzerPkg::REG_STATUS), rdata);
        expectEqual(rdata, 32'h0, "STATUS after reset");
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            expectEqual(32'(pwm), 32'h0, "pwm after reset");
        end
        // Writes to unmapped offsets are dropped
        busWrite(regAddr(4), 32'hdeadbeef);
        busRead(regAddr(4), rdata);
        expectEqual(rdata, 32'h0, "unmapped offset 4");
        busRead(regAddr(37), rdata);
        expectEqual(rdata, 32'h0, "unmapped offset 37");
        busRead(regAddr(RAM_WORDS - 1), rdata);
        expectEqual(rdata, 32'h0, "unmapped top offset");
        busRead(regAddr(buzzerPkg::REG_CTRL), rdata);
        expectEqual(rdata, 32'h0, "CTRL readback");
    endtask

    task automatic testRamAccess();
        logic [31:0]       rdata;
        logic [31:0]       wdata;
        logic [RAM_AW-1:0] addr;
        int                addrs [$];
        int                idx;
        int                i;
        for (i = 0; i < 16; i++) begin
            addr  = RAM_AW'($random(seed));
            wdata = $random(seed);
            busWrite({1'b0, addr}, wdata);
            model[int'(addr)] = wdata;
            addrs.push_back(int'(addr));
            busRead({1'b0, addr}, rdata);
            expectEqual(rdata, wdata, "RAM readback");
        end
        for (i = 0; i < 16; i++) begin
            idx = addrs[$unsigned($random(seed)) % addrs.size()];
            busRead(ADDR_WIDTH'(idx), rdata);
            expectEqual(rdata, model[idx], "RAM random read");
        end
    endtask

    task automatic testPlayback();
        loadSamples(40, 5);
        startPlay(40, 5);
        waitIdle(600);
        checkPulses();
    endtask

    task automatic testStatusRestart();
        logic [31:0] status;
        int          n;
        loadSamples(100, 3);
        startPlay(100, 3);
        busRead(regAddr(buzzerPkg::REG_STATUS), status);
        expectEqual(status, 32'h1, "STATUS during playback");
        n = 0;
        while (pulses.size() < 1 && n < 4 * PERIOD) begin
            @(negedge clk);
            n++;
        end
        assert (pulses.size() >= 1) else begin
            timeoutErrors++;
            $display("No pwm pulse seen after start");
        end
        // Retarget and start again while busy
        busWrite(regAddr(buzzerPkg::REG_BASE), 32'h0);
        busWrite(regAddr(buzzerPkg::REG_CTRL), 32'(1 << buzzerPkg::CTRL_START_BIT));
        waitIdle(600);
        checkPulses();
    endtask

    task automatic testStop();
        int n;
        int pulsesAtStop;
        loadSamples(200, 7);
        startPlay(200, 7);
        n = 0;
        while (!(pulses.size() >= 2 && pwm) && n < 6 * PERIOD) begin
            @(negedge clk);
            n++;
        end
        assert (pulses.size() >= 2 && pwm) else begin
            timeoutErrors++;
            $display("Third pwm pulse never started before stop");
        end
        pulsesAtStop = pulses.size();
        busWrite(regAddr(buzzerPkg::REG_CTRL), 32'(1 << buzzerPkg::CTRL_STOP_BIT));
        waitIdle(100);
        for (n = 0; n < 2 * PERIOD; n++) begin
            @(negedge clk);
            expectEqual(32'(pwm), 32'h0, "pwm after stop");
        end
        assert (pulses.size() <= pulsesAtStop + 1) else begin
            valueErrors++;
            $display("Fail at %0t: %0d pulses after stop", $time, pulses.size() - pulsesAtStop);
        end
    endtask

    initial begin
        RSTn          = 1'b0;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        adr           = '0;
        datW          = '0;
        width         = 0;
        seed          = 60057;
        valueErrors   = 0;
        timeoutErrors = 0;
        repeat (3) @(negedge clk);
        RSTn = 1'b1;
        testIdle();
        testRamAccess();
        testPlayback();
        testStatusRestart();
        testStop();
        $display("Errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
